//--- Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing -j 0
TOP       := tb_matrix_decode_stage
FILELIST  := vlog.f
OBJ_DIR   := obj_dir
PASS_MSG  := All tests passed

SIM_BIN   := $(OBJ_DIR)/V$(TOP)
SOURCES   := $(wildcard source/*.sv) $(wildcard tb/*.sv) $(wildcard tb/*.svh)

.PHONY: all run clean

all: run

# Rebuilt only when a source or the file list changes
$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(SIM_BIN)
	@out="$$(./$(SIM_BIN))"; echo "$$out"; echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

//--- source/addr_region_decoder.sv
// Address phase decoder
// Region compare with idle hold, HSEL generation and active flag select

`timescale 1ns/1ps
`default_nettype none

module addr_region_decoder (
    input  wire                                 sel_dec,          // HSEL from input stage
    input  wire ahb_decode_pkg::decode_addr_t   decode_addr_dec,  // HADDR[31:10]
    input  wire ahb_decode_pkg::htrans_t        trans_dec,        // HTRANS from input stage
    input  wire ahb_decode_pkg::port_id_t       data_port,        // Owner of data phase
    input  wire ahb_decode_pkg::mi_resp_array_t mi_resp,          // Output stage returns
    output ahb_decode_pkg::port_id_t            addr_port,        // Port for this address
    output ahb_decode_pkg::port_sel_t           sel_mi,           // HSEL per output port
    output logic                                sel_dft_slv,      // HSEL of default slave
    output logic                                active_dec        // Active of addressed port
);

    ahb_decode_pkg::port_sel_t region_hit;    // One bit per matching region
    ahb_decode_pkg::port_id_t  region_port;   // Lowest matching port
    logic                      hold_idle;     // Keep IDLE on the data phase owner

    //----------------------------------------------------------------------
    // Region compare
    //----------------------------------------------------------------------
    always_comb
    begin
        for (int i = 0; i < ahb_decode_pkg::NUM_PORTS; i++)
        begin
            region_hit[i] = (decode_addr_dec >= ahb_decode_pkg::REGION_BASE[i]) &&
                            (decode_addr_dec <= ahb_decode_pkg::REGION_LIMIT[i]);
        end
    end

    // Priority to the lowest numbered port
    always_comb
    begin
        region_port = ahb_decode_pkg::PORT_DEFAULT;   // Unmapped space
        for (int i = ahb_decode_pkg::NUM_PORTS - 1; i >= 0; i--)
        begin
            if (region_hit[i])
            begin
                region_port = ahb_decode_pkg::port_id_t'(i);   // Lower index overwrites
            end
        end
    end

    // An IDLE transfer stays on the port that owns the data phase.
    // This avoids a spurious switch of the output stage between bursts.
    assign hold_idle = (trans_dec == ahb_decode_pkg::HTRANS_IDLE) &&
                       (data_port != ahb_decode_pkg::PORT_DEFAULT);

    assign addr_port = hold_idle ? data_port : region_port;

    //----------------------------------------------------------------------
    // Select generation
    //----------------------------------------------------------------------
    always_comb
    begin
        for (int i = 0; i < ahb_decode_pkg::NUM_PORTS; i++)
        begin
            sel_mi[i] = sel_dec && (addr_port == ahb_decode_pkg::port_id_t'(i));
        end
    end

    // Default slave select
    assign sel_dft_slv = sel_dec && (addr_port == ahb_decode_pkg::PORT_DEFAULT);

    // Active flag of the addressed output stage
    always_comb
    begin
        active_dec = 1'b1;   // Default slave always active
        for (int i = 0; i < ahb_decode_pkg::NUM_PORTS; i++)
        begin
            if (addr_port == ahb_decode_pkg::port_id_t'(i))
            begin
                active_dec = mi_resp[i].active;
            end
        end
    end

endmodule

`default_nettype wire

//--- source/ahb_decode_pkg.sv
// Shared types for the AHB matrix decode stage
// Widths, region table, port codes, response structs, default slave states

`default_nettype none

package ahb_decode_pkg;

    //----------------------------------------------------------------------
    // Bus field widths
    //----------------------------------------------------------------------
    typedef logic [21:0] decode_addr_t;   // HADDR[31:10] as seen by the decoder
    typedef logic [1:0]  htrans_t;        // HTRANS encoding
    typedef logic [1:0]  hresp_t;         // HRESP encoding
    typedef logic [31:0] data_t;          // Read data and user read data
    typedef logic [2:0]  port_id_t;       // Output port code (5 selects default slave)

    // Transfer types
    localparam htrans_t HTRANS_IDLE   = 2'b00;
    localparam htrans_t HTRANS_BUSY   = 2'b01;
    localparam htrans_t HTRANS_NONSEQ = 2'b10;
    localparam htrans_t HTRANS_SEQ    = 2'b11;

    // Slave responses
    localparam hresp_t HRESP_OKAY  = 2'b00;
    localparam hresp_t HRESP_ERROR = 2'b01;

    //----------------------------------------------------------------------
    // Port map and decode regions
    //----------------------------------------------------------------------
    localparam int       NUM_PORTS    = 5;      // MI1 to MI5
    localparam port_id_t PORT_DEFAULT = 3'd5;   // Local default slave

    // Region bounds in 1 KB units, MI1 first
    localparam decode_addr_t REGION_BASE [NUM_PORTS] = '{
        22'h040000,   // MI1 0x1000_0000
        22'h080000,   // MI2 0x2000_0000
        22'h0C0000,   // MI3 0x3000_0000
        22'h100000,   // MI4 0x4000_0000
        22'h140000    // MI5 0x5000_0000
    };

    // Inclusive upper bounds
    localparam decode_addr_t REGION_LIMIT [NUM_PORTS] = '{
        22'h04003F,   // MI1 64 KB
        22'h08003F,   // MI2 64 KB
        22'h0FFFFF,   // MI3 256 MB
        22'h10003F,   // MI4 64 KB
        22'h17FFFF    // MI5 256 MB
    };

    //----------------------------------------------------------------------
    // Return path from the output stages
    //----------------------------------------------------------------------
    typedef struct packed {
        logic   active;     // Output stage busy with this input
        logic   readyout;   // HREADYOUT
        hresp_t resp;       // HRESP
        data_t  rdata;      // HRDATA
        data_t  ruser;      // HRUSER
    } mi_resp_t;            // 68 bits

    typedef mi_resp_t [NUM_PORTS-1:0] mi_resp_array_t;   // Index 0 is MI1
    typedef logic [NUM_PORTS-1:0]     port_sel_t;        // One HSEL per port

    // Default slave FSM
    typedef enum logic [1:0] {
        DFT_IDLE,   // OKAY with no wait
        DFT_ERR1,   // Error wait state
        DFT_ERR2    // Error completes
    } dft_state_t;

endpackage

`default_nettype wire

//--- source/data_phase_mux.sv
// Data phase port register and response multiplexer
// Returns ready, response and read data of the port owning the data phase

`timescale 1ns/1ps
`default_nettype none

module data_phase_mux (
    input  wire                                 HCLK,           // AHB clock
    input  wire                                 HRESETn,        // Sync reset, active low
    input  wire                                 HREADYS,        // Address phase ends
    input  wire ahb_decode_pkg::port_id_t       addr_port,      // Port of current address
    input  wire ahb_decode_pkg::mi_resp_array_t mi_resp,        // Output stage returns
    input  wire                                 dft_readyout,   // Default slave HREADYOUT
    input  wire ahb_decode_pkg::hresp_t         dft_resp,       // Default slave HRESP
    output ahb_decode_pkg::port_id_t            data_port,      // Owner of data phase
    output logic                                HREADYOUTS,     // Ready back to input stage
    output ahb_decode_pkg::hresp_t              HRESPS,         // Response back
    output ahb_decode_pkg::data_t               HRDATAS,        // Read data back
    output ahb_decode_pkg::data_t               HRUSERS         // User read data back
);

    //----------------------------------------------------------------------
    // Data phase owner
    //----------------------------------------------------------------------
    // HREADYS is used here and not HREADYOUTS. The input stage can end an
    // address phase from its holding register while this port still stalls.
    always_ff @(posedge HCLK)
    begin
        if (!HRESETn)
        begin
            data_port <= ahb_decode_pkg::PORT_DEFAULT;   // Idle default slave
        end
        else if (HREADYS)
        begin
            data_port <= addr_port;   // Address phase accepted
        end
    end

    //----------------------------------------------------------------------
    // Response multiplexer
    //----------------------------------------------------------------------
    always_comb
    begin
        // Default slave returns no data
        HREADYOUTS = dft_readyout;
        HRESPS     = dft_resp;
        HRDATAS    = '0;
        HRUSERS    = '0;

        for (int i = 0; i < ahb_decode_pkg::NUM_PORTS; i++)
        begin
            if (data_port == ahb_decode_pkg::port_id_t'(i))
            begin
                HREADYOUTS = mi_resp[i].readyout;
                HRESPS     = mi_resp[i].resp;
                HRDATAS    = mi_resp[i].rdata;
                HRUSERS    = mi_resp[i].ruser;
            end
        end
    end

endmodule

`default_nettype wire

//--- source/default_slave.sv
// AHB default slave for unmapped addresses
// Two-cycle ERROR for active transfers, OKAY for IDLE and BUSY

`timescale 1ns/1ps
`default_nettype none

module default_slave (
    input  wire                           HCLK,           // AHB clock
    input  wire                           HRESETn,        // Sync reset, active low
    input  wire                           sel_dft_slv,    // Selected by the decoder
    input  wire ahb_decode_pkg::htrans_t  trans_dec,      // HTRANS
    input  wire                           HREADYS,        // Address phase ends
    output logic                          dft_readyout,   // HREADYOUT
    output ahb_decode_pkg::hresp_t        dft_resp        // HRESP
);

    ahb_decode_pkg::dft_state_t state;       // Current response phase
    ahb_decode_pkg::dft_state_t state_nxt;
    logic                       err_req;     // Active transfer to unmapped space

    //----------------------------------------------------------------------
    // Transfer qualification
    //----------------------------------------------------------------------
    always_comb
    begin
        case (trans_dec)
            ahb_decode_pkg::HTRANS_NONSEQ,
            ahb_decode_pkg::HTRANS_SEQ:
                err_req = sel_dft_slv;
            default:
                err_req = 1'b0;   // IDLE and BUSY need no error
        endcase
    end

    //----------------------------------------------------------------------
    // Next state
    //----------------------------------------------------------------------
    always_comb
    begin
        state_nxt = state;
        case (state)
            ahb_decode_pkg::DFT_ERR1:
                state_nxt = ahb_decode_pkg::DFT_ERR2;   // Wait state always ends
            default:
            begin
                // IDLE or ERR2 completes a data phase here
                if (HREADYS)
                begin
                    if (err_req)
                        state_nxt = ahb_decode_pkg::DFT_ERR1;
                    else
                        state_nxt = ahb_decode_pkg::DFT_IDLE;
                end
            end
        endcase
    end

    always_ff @(posedge HCLK)
    begin
        if (!HRESETn)
            state <= ahb_decode_pkg::DFT_IDLE;
        else
            state <= state_nxt;
    end

    // Outputs straight from state
    assign dft_readyout = (state != ahb_decode_pkg::DFT_ERR1);   // Low only in wait
    assign dft_resp     = (state == ahb_decode_pkg::DFT_IDLE) ? ahb_decode_pkg::HRESP_OKAY
                                                              : ahb_decode_pkg::HRESP_ERROR;

endmodule

`default_nettype wire

//--- source/matrix_decode_stage.sv
// Bus matrix decode stage for one slave side input
// Address decoder, default slave and data phase response multiplexer

`timescale 1ns/1ps
`default_nettype none

module matrix_decode_stage (
    // Common AHB
    input  wire                                 HCLK,             // AHB clock
    input  wire                                 HRESETn,          // Sync reset, active low

    // From the input stage
    input  wire                                 HREADYS,          // Transfer done
    input  wire                                 sel_dec,          // HSEL
    input  wire ahb_decode_pkg::decode_addr_t   decode_addr_dec,  // HADDR[31:10]
    input  wire ahb_decode_pkg::htrans_t        trans_dec,        // HTRANS

    // Output stages
    input  wire ahb_decode_pkg::mi_resp_array_t mi_resp,          // Returns from MI1 to MI5
    output ahb_decode_pkg::port_sel_t           sel_mi,           // HSEL to MI1 to MI5

    // Selected port back to the input stage
    output logic                                active_dec,       // Addressed port active
    output logic                                HREADYOUTS,       // HREADY feedback
    output ahb_decode_pkg::hresp_t              HRESPS,           // Transfer response
    output ahb_decode_pkg::data_t               HRDATAS,          // Read data
    output ahb_decode_pkg::data_t               HRUSERS           // User read data
);

    ahb_decode_pkg::port_id_t addr_port;      // Address phase port
    ahb_decode_pkg::port_id_t data_port;      // Data phase port
    logic                     sel_dft_slv;    // Default slave HSEL
    logic                     dft_readyout;   // Default slave HREADYOUT
    ahb_decode_pkg::hresp_t   dft_resp;       // Default slave HRESP

    //----------------------------------------------------------------------
    // Address phase
    //----------------------------------------------------------------------
    addr_region_decoder u_addr_region_decoder (
        .sel_dec         (sel_dec),
        .decode_addr_dec (decode_addr_dec),
        .trans_dec       (trans_dec),
        .data_port       (data_port),
        .mi_resp         (mi_resp),
        .addr_port       (addr_port),
        .sel_mi          (sel_mi),
        .sel_dft_slv     (sel_dft_slv),
        .active_dec      (active_dec)
    );

    // Unmapped accesses land here
    default_slave u_default_slave (
        .HCLK         (HCLK),
        .HRESETn      (HRESETn),
        .sel_dft_slv  (sel_dft_slv),
        .trans_dec    (trans_dec),
        .HREADYS      (HREADYS),
        .dft_readyout (dft_readyout),
        .dft_resp     (dft_resp)
    );

    //----------------------------------------------------------------------
    // Data phase
    //----------------------------------------------------------------------
    data_phase_mux u_data_phase_mux (
        .HCLK         (HCLK),
        .HRESETn      (HRESETn),
        .HREADYS      (HREADYS),
        .addr_port    (addr_port),
        .mi_resp      (mi_resp),
        .dft_readyout (dft_readyout),
        .dft_resp     (dft_resp),
        .data_port    (data_port),
        .HREADYOUTS   (HREADYOUTS),
        .HRESPS       (HRESPS),
        .HRDATAS      (HRDATAS),
        .HRUSERS      (HRUSERS)
    );

endmodule

`default_nettype wire

//--- tb/tb_checks.svh
// Typed compare tasks for the decode stage testbench
// Check and error counters shared by all tests

`ifndef TB_CHECKS_SVH
`define TB_CHECKS_SVH

int check_count = 0;   // Compares done
int error_count = 0;   // Compares that failed

//----------------------------------------------------------------------
// Compare tasks, one per result type
//----------------------------------------------------------------------
task automatic check_port_sel(input string                     name,
                              input ahb_decode_pkg::port_sel_t got,
                              input ahb_decode_pkg::port_sel_t exp);
    check_count++;
    if (got !== exp)
    begin
        error_count++;
        $display("Mismatch %s: got 0x%0h, expected 0x%0h at %0t", name, got, exp, $time);
    end
endtask

task automatic check_bit(input string name, input logic got, input logic exp);
    check_count++;
    if (got !== exp)
    begin
        error_count++;
        $display("Mismatch %s: got 0x%0h, expected 0x%0h at %0t", name, got, exp, $time);
    end
endtask

// HRESP compare
task automatic check_resp(input string                  name,
                          input ahb_decode_pkg::hresp_t got,
                          input ahb_decode_pkg::hresp_t exp);
    check_count++;
    if (got !== exp)
    begin
        error_count++;
        $display("Mismatch %s: got 0x%0h, expected 0x%0h at %0t", name, got, exp, $time);
    end
endtask

// Read data and user data compare
task automatic check_data(input string                 name,
                          input ahb_decode_pkg::data_t got,
                          input ahb_decode_pkg::data_t exp);
    check_count++;
    if (got !== exp)
    begin
        error_count++;
        $display("Mismatch %s: got 0x%08h, expected 0x%08h at %0t", name, got, exp, $time);
    end
endtask

`endif

//--- tb/tb_matrix_decode_stage.sv
// Testbench for the bus matrix decode stage
// Clock, reset, watchdog, directed tests and run summary

`timescale 1ns/1ps
`default_nettype none

module tb_matrix_decode_stage;

    localparam int CLK_PERIOD      = 4;     // ns
    localparam int NUM_TESTS       = 5;
    localparam int CYCLES_PER_TEST = 200;   // Watchdog budget per test

    logic                           HCLK;
    logic                           HRESETn;
    logic                           HREADYS;
    logic                           sel_dec;
    ahb_decode_pkg::decode_addr_t   decode_addr_dec;
    ahb_decode_pkg::htrans_t        trans_dec;
    ahb_decode_pkg::mi_resp_array_t mi_resp;           // Output stage model
    ahb_decode_pkg::port_sel_t      sel_mi;
    logic                           active_dec;
    logic                           HREADYOUTS;
    ahb_decode_pkg::hresp_t         HRESPS;
    ahb_decode_pkg::data_t          HRDATAS;
    ahb_decode_pkg::data_t          HRUSERS;

    int tests_run    = 0;
    int tests_failed = 0;

    `include "tb_checks.svh"

    matrix_decode_stage DUT (
        .HCLK            (HCLK),
        .HRESETn         (HRESETn),
        .HREADYS         (HREADYS),
        .sel_dec         (sel_dec),
        .decode_addr_dec (decode_addr_dec),
        .trans_dec       (trans_dec),
        .mi_resp         (mi_resp),
        .sel_mi          (sel_mi),
        .active_dec      (active_dec),
        .HREADYOUTS      (HREADYOUTS),
        .HRESPS          (HRESPS),
        .HRDATAS         (HRDATAS),
        .HRUSERS         (HRUSERS)
    );

    always #(CLK_PERIOD / 2) HCLK = ~HCLK;

    //----------------------------------------------------------------------
    // Stimulus helpers
    //----------------------------------------------------------------------
    task automatic next_cycle();
        @(posedge HCLK);
        #1;   // Drive point after the edge
    endtask

    task automatic drive_addr(input logic                         sel,
                              input ahb_decode_pkg::decode_addr_t addr,
                              input ahb_decode_pkg::htrans_t      trans,
                              input logic                         ready);
        sel_dec         = sel;
        decode_addr_dec = addr;
        trans_dec       = trans;
        HREADYS         = ready;
    endtask

    // Random data and active flags, all ports ready with OKAY
    task automatic fill_responses();
        ahb_decode_pkg::port_id_t p;
        logic [31:0]              rnd;
        for (int i = 0; i < ahb_decode_pkg::NUM_PORTS; i++)
        begin
            p   = ahb_decode_pkg::port_id_t'(i);
            rnd = $urandom;
            mi_resp[p].active   = rnd[0];
            mi_resp[p].readyout = 1'b1;
            mi_resp[p].resp     = ahb_decode_pkg::HRESP_OKAY;
            mi_resp[p].rdata    = $urandom;
            mi_resp[p].ruser    = $urandom;
        end
    endtask

    //----------------------------------------------------------------------
    // Reference decode and response compares
    //----------------------------------------------------------------------
    function automatic ahb_decode_pkg::port_id_t expected_port(
        input ahb_decode_pkg::decode_addr_t a,
        input ahb_decode_pkg::htrans_t      t,
        input ahb_decode_pkg::port_id_t     owner);
        ahb_decode_pkg::port_id_t p;
        ahb_decode_pkg::port_id_t k;
        logic                     found;
        p     = ahb_decode_pkg::PORT_DEFAULT;
        found = 1'b0;
        for (int i = 0; i < ahb_decode_pkg::NUM_PORTS; i++)
        begin
            k = ahb_decode_pkg::port_id_t'(i);
            if (!found && a >= ahb_decode_pkg::REGION_BASE[k] &&
                a <= ahb_decode_pkg::REGION_LIMIT[k])
            begin
                p     = k;      // First hit wins
                found = 1'b1;
            end
        end
        if (t == ahb_decode_pkg::HTRANS_IDLE && owner != ahb_decode_pkg::PORT_DEFAULT)
            p = owner;          // Idle hold
        return p;
    endfunction

    // Address phase outputs against the current inputs
    task automatic compare_decode(input ahb_decode_pkg::port_id_t owner);
        ahb_decode_pkg::port_id_t  p;
        ahb_decode_pkg::port_sel_t exp_sel;
        logic                      exp_active;
        p          = expected_port(decode_addr_dec, trans_dec, owner);
        exp_sel    = '0;
        exp_active = 1'b1;   // Default slave
        if (p != ahb_decode_pkg::PORT_DEFAULT)
        begin
            if (sel_dec)
                exp_sel = ahb_decode_pkg::port_sel_t'(5'd1 << p);
            exp_active = mi_resp[p].active;
        end
        check_port_sel("sel_mi", sel_mi, exp_sel);
        check_bit("sel_dft_slv", DUT.sel_dft_slv,
                  sel_dec && (p == ahb_decode_pkg::PORT_DEFAULT));
        check_bit("active_dec", active_dec, exp_active);
    endtask

    task automatic compare_return(input logic                   rdy,
                                  input ahb_decode_pkg::hresp_t resp,
                                  input ahb_decode_pkg::data_t  rdata,
                                  input ahb_decode_pkg::data_t  ruser);
        check_bit("HREADYOUTS", HREADYOUTS, rdy);
        check_resp("HRESPS", HRESPS, resp);
        check_data("HRDATAS", HRDATAS, rdata);
        check_data("HRUSERS", HRUSERS, ruser);
    endtask

    task automatic return_from_port(input ahb_decode_pkg::port_id_t p);
        compare_return(mi_resp[p].readyout, mi_resp[p].resp, mi_resp[p].rdata, mi_resp[p].ruser);
    endtask

    task automatic finish_test(input string name, input int errs_before);
        tests_run++;
        if (error_count == errs_before)
        begin
            $display("Test %s: pass", name);
        end
        else
        begin
            tests_failed++;
            $display("Test %s: FAIL with %0d errors", name, error_count - errs_before);
        end
    endtask

    //----------------------------------------------------------------------
    // Directed tests
    //----------------------------------------------------------------------
    task automatic reset_values();
        int errs;
        errs = error_count;
        drive_addr(1'b0, '0, ahb_decode_pkg::HTRANS_IDLE, 1'b1);
        #1;
        compare_return(1'b1, ahb_decode_pkg::HRESP_OKAY, '0, '0);   // Default slave idle
        check_port_sel("sel_mi", sel_mi, '0);
        finish_test("reset_values", errs);
    endtask

    // Base, limit and both neighbours of every region
    task automatic region_routing();
        int                           errs;
        ahb_decode_pkg::port_id_t     k;
        ahb_decode_pkg::decode_addr_t probe [4];
        errs = error_count;
        for (int i = 0; i < ahb_decode_pkg::NUM_PORTS; i++)
        begin
            k        = ahb_decode_pkg::port_id_t'(i);
            probe[0] = ahb_decode_pkg::REGION_BASE[k];
            probe[1] = ahb_decode_pkg::REGION_LIMIT[k];
            probe[2] = ahb_decode_pkg::REGION_BASE[k] - 22'd1;
            probe[3] = ahb_decode_pkg::REGION_LIMIT[k] + 22'd1;
            for (int j = 0; j < 4; j++)
            begin
                next_cycle();
                drive_addr(1'b1, probe[j], ahb_decode_pkg::HTRANS_NONSEQ, 1'b0);
                #1;
                compare_decode(ahb_decode_pkg::PORT_DEFAULT);
            end
        end
        next_cycle();
        drive_addr(1'b0, ahb_decode_pkg::REGION_BASE[2], ahb_decode_pkg::HTRANS_NONSEQ, 1'b0);
        #1;
        compare_decode(ahb_decode_pkg::PORT_DEFAULT);   // No select without sel_dec
        finish_test("region_routing", errs);
    endtask

    // MI2 owns the data phase while MI4 waits in the address phase
    task automatic data_phase_return();
        int errs;
        errs = error_count;
        next_cycle();
        drive_addr(1'b1, ahb_decode_pkg::REGION_BASE[1], ahb_decode_pkg::HTRANS_NONSEQ, 1'b1);
        next_cycle();
        mi_resp[1].readyout = 1'b0;                          // MI2 inserts wait states
        mi_resp[1].resp     = ahb_decode_pkg::HRESP_ERROR;   // MI2 answers ERROR
        drive_addr(1'b1, ahb_decode_pkg::REGION_BASE[3], ahb_decode_pkg::HTRANS_NONSEQ, 1'b0);
        #1;
        return_from_port(3'd1);
        compare_decode(3'd1);
        repeat (3)
        begin
            next_cycle();
            drive_addr(1'b1, ahb_decode_pkg::REGION_LIMIT[2], ahb_decode_pkg::HTRANS_NONSEQ,
                       1'b0);
            #1;
            return_from_port(3'd1);   // Held under back-pressure
        end
        next_cycle();
        mi_resp[1].readyout = 1'b1;
        drive_addr(1'b1, ahb_decode_pkg::REGION_BASE[3], ahb_decode_pkg::HTRANS_NONSEQ, 1'b1);
        #1;
        return_from_port(3'd1);
        next_cycle();
        drive_addr(1'b0, '0, ahb_decode_pkg::HTRANS_IDLE, 1'b1);
        #1;
        return_from_port(3'd3);   // MI4 now owns the data phase
        mi_resp[1].resp = ahb_decode_pkg::HRESP_OKAY;
        finish_test("data_phase_return", errs);
    endtask

    task automatic default_slave_error();
        int errs;
        errs = error_count;
        next_cycle();
        drive_addr(1'b1, '0, ahb_decode_pkg::HTRANS_NONSEQ, 1'b1);   // Unmapped
        #1;
        compare_decode(3'd3);
        next_cycle();
        drive_addr(1'b0, '0, ahb_decode_pkg::HTRANS_IDLE, 1'b0);
        #1;
        compare_return(1'b0, ahb_decode_pkg::HRESP_ERROR, '0, '0);   // Wait state
        next_cycle();
        drive_addr(1'b0, '0, ahb_decode_pkg::HTRANS_IDLE, 1'b1);
        #1;
        compare_return(1'b1, ahb_decode_pkg::HRESP_ERROR, '0, '0);
        next_cycle();
        drive_addr(1'b1, '0, ahb_decode_pkg::HTRANS_IDLE, 1'b1);     // Idle to unmapped
        #1;
        compare_return(1'b1, ahb_decode_pkg::HRESP_OKAY, '0, '0);
        compare_decode(ahb_decode_pkg::PORT_DEFAULT);
        next_cycle();
        drive_addr(1'b0, '0, ahb_decode_pkg::HTRANS_IDLE, 1'b1);
        #1;
        compare_return(1'b1, ahb_decode_pkg::HRESP_OKAY, '0, '0);   // No wait state
        finish_test("default_slave_error", errs);
    endtask

    task automatic idle_hold();
        int errs;
        errs = error_count;
        next_cycle();
        drive_addr(1'b1, ahb_decode_pkg::REGION_BASE[0], ahb_decode_pkg::HTRANS_NONSEQ, 1'b1);
        #1;
        compare_decode(ahb_decode_pkg::PORT_DEFAULT);
        next_cycle();
        drive_addr(1'b1, ahb_decode_pkg::REGION_BASE[4], ahb_decode_pkg::HTRANS_IDLE, 1'b1);
        #1;
        compare_decode(3'd0);      // Stays on MI1
        return_from_port(3'd0);
        next_cycle();
        drive_addr(1'b1, ahb_decode_pkg::REGION_BASE[4], ahb_decode_pkg::HTRANS_NONSEQ, 1'b1);
        #1;
        compare_decode(3'd0);      // Active transfer moves to MI5
        next_cycle();
        drive_addr(1'b0, '0, ahb_decode_pkg::HTRANS_IDLE, 1'b1);
        #1;
        compare_decode(3'd4);
        return_from_port(3'd4);
        finish_test("idle_hold", errs);
    endtask

    //----------------------------------------------------------------------
    // Main sequence and watchdog
    //----------------------------------------------------------------------
    initial
    begin
        void'($urandom(32'heab1));
        HCLK            = 1'b0;
        HRESETn         = 1'b0;
        HREADYS         = 1'b1;
        sel_dec         = 1'b0;
        decode_addr_dec = '0;
        trans_dec       = ahb_decode_pkg::HTRANS_IDLE;
        mi_resp         = '0;
        fill_responses();
        repeat (2) @(posedge HCLK);
        #1;
        HRESETn = 1'b1;
        reset_values();
        region_routing();
        data_phase_return();
        default_slave_error();
        idle_hold();
        $display("Summary: %0d tests, %0d failed, %0d checks, %0d errors",
                 tests_run, tests_failed, check_count, error_count);
        if (error_count == 0 && tests_failed == 0)
            $display("All tests passed");
        else
            $display("Some tests failed");
        $finish;
    end

    initial
    begin
        #(NUM_TESTS * CYCLES_PER_TEST * CLK_PERIOD);
        $display("Timeout: the tests did not finish within %0d cycles",
                 NUM_TESTS * CYCLES_PER_TEST);
        $display("Some tests failed");
        $finish;
    end

endmodule

`default_nettype wire

//--- vlog.f
+incdir+tb
source/ahb_decode_pkg.sv
source/addr_region_decoder.sv
source/default_slave.sv
source/data_phase_mux.sv
source/matrix_decode_stage.sv
tb/tb_matrix_decode_stage.sv
